// File: build.f
+incdir+common
common/touch_pkg.sv
src/key_decoder.sv
src/key_release.sv
src/screen_fsm.sv
scope/scope_controls.sv
keypad/digit_entry.sv
src/touch_panel_top.sv
tb/tb_touch_panel.sv

// File: common/touch_defines.svh
`ifndef TOUCH_DEFINES_SVH
`define TOUCH_DEFINES_SVH

`define H_ACT         1024
`define V_ACT         600
`define KEY_MARGIN_X  30
`define KEY_MARGIN_Y  28
`define TARGET_DIGITS 3

`define H_FIFTH    (`H_ACT / 5)
`define H_TENTH    (`H_ACT / 10)
`define V_SIXTH    (`V_ACT / 6)
`define KP_PITCH_X (2 * (`H_ACT / 15))

// each rectangle expands to xl, xh, yl, yh
`define RECT_MENU_SCOPE       390, 630, 200, 448
`define RECT_MENU_KEYPAD      705, 945, 200, 448
`define RECT_SCOPE_BACK       (3 * `H_FIFTH), (`H_ACT - `H_FIFTH), 0, `V_SIXTH
`define RECT_SCOPE_SPECTRUM   (2 * `H_FIFTH), (3 * `H_FIFTH), 0, `V_SIXTH
`define RECT_SCOPE_TRACE1     10, `H_FIFTH, 10, `V_SIXTH
`define RECT_SCOPE_TRACE2     (`H_ACT - `H_FIFTH), `H_ACT, 0, `V_SIXTH
`define RECT_SCOPE_STOP       `H_FIFTH, (2 * `H_FIFTH), (`V_ACT - `V_SIXTH), `V_ACT
`define RECT_SCOPE_DIFF       (3 * `H_FIFTH), (`H_ACT - `H_FIFTH), (`V_ACT - `V_SIXTH), `V_ACT
`define RECT_SCOPE_CURSOR     (2 * `H_FIFTH), (3 * `H_FIFTH), (`V_ACT - `V_SIXTH), `V_ACT
`define RECT_SCOPE_CLEAR      `H_FIFTH, (2 * `H_FIFTH), 0, `V_SIXTH
`define RECT_SCOPE_PAN_X1     0, `H_TENTH, (`V_ACT - `V_SIXTH), `V_ACT
`define RECT_SCOPE_PAN_X2     `H_TENTH, `H_FIFTH, (`V_ACT - `V_SIXTH), `V_ACT
`define RECT_SCOPE_PAN_Y_UP   (`H_ACT - `H_FIFTH), (`H_ACT - `H_TENTH), (`V_ACT - `V_SIXTH), `V_ACT
`define RECT_SCOPE_PAN_Y_DOWN (`H_ACT - `H_TENTH), `H_ACT, (`V_ACT - `V_SIXTH), `V_ACT
`define RECT_SPECTRUM_BACK    (`H_ACT - `H_FIFTH), `H_ACT, 0, `V_SIXTH
`define RECT_KEYPAD_CLEAR     (3 * `H_FIFTH + 55), (`H_ACT - `H_FIFTH - 55), \
                              `KEY_MARGIN_Y, (`V_SIXTH - `KEY_MARGIN_Y)
`define RECT_KEYPAD_BACK      `H_FIFTH, (2 * `H_FIFTH), 0, `V_SIXTH

// phone-style digit grid, 0 sits under 8
`define KP_COL(d) ((d) == 0 ? 1 : ((d) - 1) % 3)
`define KP_ROW(d) ((d) == 0 ? 3 : ((d) - 1) / 3)
`define KP_Y(d)   (`V_SIXTH * (`KP_ROW(d) + 1) + `KEY_MARGIN_Y), \
                  (`V_SIXTH * (`KP_ROW(d) + 2) - `KEY_MARGIN_Y)
`define RECT_FRE(d) (3 * `H_FIFTH + `KP_COL(d) * `KP_PITCH_X + `KEY_MARGIN_X), \
                    (3 * `H_FIFTH + (`KP_COL(d) + 1) * `KP_PITCH_X - `KEY_MARGIN_X), `KP_Y(d)
`define RECT_VPP(d) (`KP_COL(d) * `KP_PITCH_X + `KEY_MARGIN_X), \
                    ((`KP_COL(d) + 1) * `KP_PITCH_X - `KEY_MARGIN_X), `KP_Y(d)

`endif

// File: common/touch_pkg.sv
package touch_pkg;

    typedef logic [15:0] coord_t;   // pixels
    typedef logic [10:0] target_t;
    typedef logic [2:0]  pan_t;
    typedef logic [4:0]  vpan_t;

    typedef enum logic [1:0] {
        screen_menu,
        screen_scope,
        screen_spectrum,
        screen_keypad
    } screen_t;

    // order is the hit priority in the decoder
    typedef enum logic [5:0] {
        key_none,
        menu_scope, menu_keypad,
        scope_back, scope_spectrum, scope_trace1, scope_trace2,
        scope_stop, scope_diff, scope_cursor, scope_clear,
        scope_pan_x1, scope_pan_x2, scope_pan_y_up, scope_pan_y_down,
        spectrum_back,
        fre_0, fre_1, fre_2, fre_3, fre_4, fre_5, fre_6, fre_7, fre_8, fre_9,
        vpp_0, vpp_1, vpp_2, vpp_3, vpp_4, vpp_5, vpp_6, vpp_7, vpp_8, vpp_9,
        keypad_clear, keypad_back
    } key_t;

    function automatic logic key_is_fre(key_t k);
        return (k >= fre_0) && (k <= fre_9);
    endfunction

    function automatic logic key_is_vpp(key_t k);
        return (k >= vpp_0) && (k <= vpp_9);
    endfunction

    function automatic logic [3:0] key_digit(key_t k);
        if (key_is_fre(k))
            return 4'(k - fre_0);
        else if (key_is_vpp(k))
            return 4'(k - vpp_0);
        return 4'd0;   // not a digit key
    endfunction

endpackage

// File: keypad/digit_entry.sv
`timescale 1ns/1ps
`include "touch_defines.svh"

module digit_entry #(
    parameter int DIGITS  = `TARGET_DIGITS,
    parameter bit FRE_PAD = 1'b1   // 1 serves the fre pad, 0 the vpp pad
) (
    input  logic               clk,
    input  logic               reset,
    input  touch_pkg::key_t    released,
    output touch_pkg::target_t value
);

    localparam int CNT_W = $clog2(DIGITS + 1);

    logic [CNT_W-1:0]   count;     // digits entered so far
    logic               own_key;
    touch_pkg::target_t weight;    // place value of the next digit

    assign own_key = FRE_PAD ? touch_pkg::key_is_fre(released)
                             : touch_pkg::key_is_vpp(released);

    // 10 ** (DIGITS - 1 - count)
    always_comb begin
        weight = 1;
        for (int i = 0; i < DIGITS - 1; i++) begin
            if (i >= count)
                weight = touch_pkg::target_t'(weight * 10);
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            value <= '0;
            count <= '0;
        end else if (released == touch_pkg::keypad_clear) begin
            value <= '0;   // clears both pads
            count <= '0;
        end else if (own_key && count < DIGITS) begin
            value <= value + touch_pkg::key_digit(released) * weight;
            count <= count + 1'b1;
        end
    end

    // once full, the count and the value hold until a clear
    a_count_saturates: assert property (@(posedge clk) disable iff (!reset)
        (count == DIGITS && released != touch_pkg::keypad_clear)
        |=> (count == DIGITS && $stable(value)));

endmodule

// File: scope/scope_controls.sv
`timescale 1ns/1ps

module scope_controls (
    input  logic             clk,
    input  logic             reset,
    input  touch_pkg::key_t  released,
    output logic             trace1_on,
    output logic             trace2_on,
    output logic             spectrum_on,
    output logic             run_stop,
    output logic             diff_on,
    output logic             cursor_on,
    output touch_pkg::pan_t  pan_x1,
    output touch_pkg::pan_t  pan_x2,
    output touch_pkg::vpan_t pan_y
);

    localparam touch_pkg::pan_t PAN_X2_INIT = 3'd1;   // second trace starts offset

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            trace1_on   <= 1'b0;
            trace2_on   <= 1'b0;
            spectrum_on <= 1'b0;
            run_stop    <= 1'b0;
            diff_on     <= 1'b0;
            cursor_on   <= 1'b0;
            pan_x1      <= '0;
            pan_x2      <= PAN_X2_INIT;
            pan_y       <= '0;
        end else begin
            case (released)
                touch_pkg::scope_trace1:     trace1_on   <= ~trace1_on;
                touch_pkg::scope_trace2:     trace2_on   <= ~trace2_on;
                touch_pkg::scope_spectrum:   spectrum_on <= ~spectrum_on;
                touch_pkg::scope_stop:       run_stop    <= ~run_stop;
                touch_pkg::scope_diff:       diff_on     <= ~diff_on;
                touch_pkg::scope_cursor:     cursor_on   <= ~cursor_on;
                touch_pkg::scope_pan_x1:     pan_x1      <= pan_x1 + 1'b1;   // wraps
                touch_pkg::scope_pan_x2:     pan_x2      <= pan_x2 + 1'b1;
                touch_pkg::scope_pan_y_up:   pan_y       <= pan_y + 1'b1;
                touch_pkg::scope_pan_y_down: pan_y       <= pan_y - 1'b1;    // 0 -> 31
                touch_pkg::scope_clear: begin
                    trace1_on   <= 1'b0;
                    trace2_on   <= 1'b0;
                    spectrum_on <= 1'b0;
                    run_stop    <= 1'b0;
                    diff_on     <= 1'b0;
                    cursor_on   <= 1'b0;
                    pan_x1      <= '0;
                    pan_x2      <= PAN_X2_INIT;
                    pan_y       <= '0;
                end
                default: ;
            endcase
        end
    end

endmodule

// File: src/key_decoder.sv
`timescale 1ns/1ps
`include "touch_defines.svh"

module key_decoder (
    input  logic               clk,
    input  logic               reset,
    input  touch_pkg::coord_t  touch_x,
    input  touch_pkg::coord_t  touch_y,
    input  touch_pkg::screen_t screen,
    output touch_pkg::key_t    key,
    output logic               key_active
);

    touch_pkg::key_t hit;

    function automatic logic in_rect(
        input touch_pkg::coord_t x,
        input touch_pkg::coord_t y,
        input int                xl,
        input int                xh,
        input int                yl,
        input int                yh
    );
        return (x >= xl) && (x <= xh) && (y >= yl) && (y <= yh);   // edges inclusive
    endfunction

    function automatic logic key_on_screen(touch_pkg::key_t k, touch_pkg::screen_t s);
        if (k == touch_pkg::key_none)
            return 1'b1;
        case (s)
            touch_pkg::screen_menu:     return k inside {touch_pkg::menu_scope,
                                                         touch_pkg::menu_keypad};
            touch_pkg::screen_scope:    return k inside {[touch_pkg::scope_back :
                                                          touch_pkg::scope_pan_y_down]};
            touch_pkg::screen_spectrum: return k == touch_pkg::spectrum_back;
            default:                    return k inside {[touch_pkg::fre_0 :
                                                          touch_pkg::keypad_back]};
        endcase
    endfunction

    // first rectangle in key order wins
    always_comb begin
        hit = touch_pkg::key_none;
        case (screen)
            touch_pkg::screen_menu: begin
                if (in_rect(touch_x, touch_y, `RECT_MENU_SCOPE))
                    hit = touch_pkg::menu_scope;
                else if (in_rect(touch_x, touch_y, `RECT_MENU_KEYPAD))
                    hit = touch_pkg::menu_keypad;
            end
            touch_pkg::screen_scope: begin
                if (in_rect(touch_x, touch_y, `RECT_SCOPE_BACK))
                    hit = touch_pkg::scope_back;
                else if (in_rect(touch_x, touch_y, `RECT_SCOPE_SPECTRUM))
                    hit = touch_pkg::scope_spectrum;
                else if (in_rect(touch_x, touch_y, `RECT_SCOPE_TRACE1))
                    hit = touch_pkg::scope_trace1;
                else if (in_rect(touch_x, touch_y, `RECT_SCOPE_TRACE2))
                    hit = touch_pkg::scope_trace2;
                else if (in_rect(touch_x, touch_y, `RECT_SCOPE_STOP))
                    hit = touch_pkg::scope_stop;
                else if (in_rect(touch_x, touch_y, `RECT_SCOPE_DIFF))
                    hit = touch_pkg::scope_diff;
                else if (in_rect(touch_x, touch_y, `RECT_SCOPE_CURSOR))
                    hit = touch_pkg::scope_cursor;
                else if (in_rect(touch_x, touch_y, `RECT_SCOPE_CLEAR))
                    hit = touch_pkg::scope_clear;
                else if (in_rect(touch_x, touch_y, `RECT_SCOPE_PAN_X1))
                    hit = touch_pkg::scope_pan_x1;
                else if (in_rect(touch_x, touch_y, `RECT_SCOPE_PAN_X2))
                    hit = touch_pkg::scope_pan_x2;
                else if (in_rect(touch_x, touch_y, `RECT_SCOPE_PAN_Y_UP))
                    hit = touch_pkg::scope_pan_y_up;
                else if (in_rect(touch_x, touch_y, `RECT_SCOPE_PAN_Y_DOWN))
                    hit = touch_pkg::scope_pan_y_down;
            end
            touch_pkg::screen_spectrum: begin
                if (in_rect(touch_x, touch_y, `RECT_SPECTRUM_BACK))
                    hit = touch_pkg::spectrum_back;
            end
            default: begin
                for (int d = 0; d < 10; d++) begin
                    if (hit == touch_pkg::key_none && in_rect(touch_x, touch_y, `RECT_FRE(d)))
                        hit = touch_pkg::key_t'(touch_pkg::fre_0 + d);
                end
                for (int d = 0; d < 10; d++) begin
                    if (hit == touch_pkg::key_none && in_rect(touch_x, touch_y, `RECT_VPP(d)))
                        hit = touch_pkg::key_t'(touch_pkg::vpp_0 + d);
                end
                if (hit == touch_pkg::key_none) begin
                    if (in_rect(touch_x, touch_y, `RECT_KEYPAD_CLEAR))
                        hit = touch_pkg::keypad_clear;
                    else if (in_rect(touch_x, touch_y, `RECT_KEYPAD_BACK))
                        hit = touch_pkg::keypad_back;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            key <= touch_pkg::key_none;
        else
            key <= hit;
    end

    assign key_active = (key != touch_pkg::key_none);

    // key was decoded against the screen of the previous cycle
    a_key_on_screen: assert property (@(posedge clk) disable iff (!reset)
        key_on_screen(key, $past(screen)));

endmodule

// File: src/key_release.sv
`timescale 1ns/1ps

module key_release (
    input  logic            clk,
    input  logic            reset,
    input  touch_pkg::key_t key,
    output touch_pkg::key_t released
);

    touch_pkg::key_t hist1;
    touch_pkg::key_t hist2;
    touch_pkg::key_t hist3;   // oldest
    logic            fall;

    // oldest entry is a real key and the next one moved away from it
    assign fall = (hist3 != touch_pkg::key_none) && (hist2 != hist3);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            hist1    <= touch_pkg::key_none;
            hist2    <= touch_pkg::key_none;
            hist3    <= touch_pkg::key_none;
            released <= touch_pkg::key_none;
        end else begin
            hist1    <= key;
            hist2    <= hist1;
            hist3    <= hist2;
            released <= fall ? hist3 : touch_pkg::key_none;
        end
    end

    // one pulse per release, never stretched
    a_single_pulse: assert property (@(posedge clk) disable iff (!reset)
        (released != touch_pkg::key_none) |=> (released != $past(released)));

endmodule

// File: src/screen_fsm.sv
`timescale 1ns/1ps

module screen_fsm (
    input  logic               clk,
    input  logic               reset,
    input  touch_pkg::key_t    released,
    output touch_pkg::screen_t screen
);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            screen <= touch_pkg::screen_menu;
        end else begin
            case (screen)
                touch_pkg::screen_menu: begin
                    if (released == touch_pkg::menu_scope)
                        screen <= touch_pkg::screen_scope;
                    else if (released == touch_pkg::menu_keypad)
                        screen <= touch_pkg::screen_keypad;
                end
                touch_pkg::screen_scope: begin
                    if (released == touch_pkg::scope_back)
                        screen <= touch_pkg::screen_menu;
                    else if (released == touch_pkg::scope_spectrum)
                        screen <= touch_pkg::screen_spectrum;   // also flips spectrum_on
                end
                touch_pkg::screen_spectrum: begin
                    if (released == touch_pkg::spectrum_back)
                        screen <= touch_pkg::screen_scope;
                end
                default: begin
                    if (released == touch_pkg::keypad_back)
                        screen <= touch_pkg::screen_menu;
                end
            endcase
        end
    end

    // known value, and a change only ever follows a release
    a_screen_legal: assert property (@(posedge clk) disable iff (!reset)
        !$isunknown(screen) &&
        (!$changed(screen) || ($past(released) != touch_pkg::key_none)));

endmodule

// File: src/touch_panel_top.sv
`timescale 1ns/1ps

module touch_panel_top (
    input  logic               clk,
    input  logic               reset,
    input  touch_pkg::coord_t  touch_x,
    input  touch_pkg::coord_t  touch_y,
    output touch_pkg::screen_t screen,
    output logic               key_active,
    output touch_pkg::target_t target_freq,
    output touch_pkg::target_t target_vpp,
    output logic               trace1_on,
    output logic               trace2_on,
    output logic               spectrum_on,
    output logic               run_stop,
    output logic               diff_on,
    output logic               cursor_on,
    output touch_pkg::pan_t    pan_x1,
    output touch_pkg::pan_t    pan_x2,
    output touch_pkg::vpan_t   pan_y
);

    touch_pkg::key_t key;        // registered hit
    touch_pkg::key_t released;   // one-cycle release pulse

    key_decoder u_decoder (
        .clk        (clk),
        .reset      (reset),
        .touch_x    (touch_x),
        .touch_y    (touch_y),
        .screen     (screen),
        .key        (key),
        .key_active (key_active)
    );

    key_release u_release (
        .clk      (clk),
        .reset    (reset),
        .key      (key),
        .released (released)
    );

    screen_fsm u_screen (
        .clk      (clk),
        .reset    (reset),
        .released (released),
        .screen   (screen)
    );

    scope_controls u_scope (
        .clk         (clk),
        .reset       (reset),
        .released    (released),
        .trace1_on   (trace1_on),
        .trace2_on   (trace2_on),
        .spectrum_on (spectrum_on),
        .run_stop    (run_stop),
        .diff_on     (diff_on),
        .cursor_on   (cursor_on),
        .pan_x1      (pan_x1),
        .pan_x2      (pan_x2),
        .pan_y       (pan_y)
    );

    digit_entry #(.FRE_PAD(1'b1)) u_freq_entry (
        .clk      (clk),
        .reset    (reset),
        .released (released),
        .value    (target_freq)
    );

    digit_entry #(.FRE_PAD(1'b0)) u_vpp_entry (
        .clk      (clk),
        .reset    (reset),
        .released (released),
        .value    (target_vpp)
    );

endmodule

// File: tb/tb_touch_panel.sv
`timescale 1ns/1ps
`include "touch_defines.svh"

module tb_touch_panel;

    localparam int CLK_PERIOD = 40;
    localparam int PRESSES    = 74;    // sum over all six tests
    localparam int WATCHDOG   = 16 + 20 + PRESSES * 20;
    localparam int OFF_X      = 650;   // between keys on every screen
    localparam int OFF_Y      = 300;

    logic               clk;
    logic               reset;
    touch_pkg::coord_t  touch_x;
    touch_pkg::coord_t  touch_y;
    touch_pkg::screen_t screen;
    logic               key_active;
    touch_pkg::target_t target_freq;
    touch_pkg::target_t target_vpp;
    logic               trace1_on;
    logic               trace2_on;
    logic               spectrum_on;
    logic               run_stop;
    logic               diff_on;
    logic               cursor_on;
    touch_pkg::pan_t    pan_x1;
    touch_pkg::pan_t    pan_x2;
    touch_pkg::vpan_t   pan_y;

    // reference model
    touch_pkg::screen_t m_screen;
    logic               m_trace1;
    logic               m_trace2;
    logic               m_spectrum;
    logic               m_run;
    logic               m_diff;
    logic               m_cursor;
    int                 m_pan_x1;
    int                 m_pan_x2;
    int                 m_pan_y;
    int                 m_freq;
    int                 m_vpp;
    int                 m_freq_cnt;
    int                 m_vpp_cnt;

    logic               check_now;
    logic               active_exp;
    int                 errors;
    int                 checks;
    int                 tests;
    int                 test_base;

    touch_panel_top DUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_mismatch(input string name, input int exp, input int act);
        $display("FAIL %0t %s expected %0d actual %0d", $time, name, exp, act);
        errors++;
    endtask

    a_screen: assert property (@(posedge clk) check_now |-> screen == m_screen)
        else report_mismatch("screen", int'(m_screen), int'($sampled(screen)));
    a_trace1: assert property (@(posedge clk) check_now |-> trace1_on == m_trace1)
        else report_mismatch("trace1_on", m_trace1, $sampled(trace1_on));
    a_trace2: assert property (@(posedge clk) check_now |-> trace2_on == m_trace2)
        else report_mismatch("trace2_on", m_trace2, $sampled(trace2_on));
    a_spectrum: assert property (@(posedge clk) check_now |-> spectrum_on == m_spectrum)
        else report_mismatch("spectrum_on", m_spectrum, $sampled(spectrum_on));
    a_run: assert property (@(posedge clk) check_now |-> run_stop == m_run)
        else report_mismatch("run_stop", m_run, $sampled(run_stop));
    a_diff: assert property (@(posedge clk) check_now |-> diff_on == m_diff)
        else report_mismatch("diff_on", m_diff, $sampled(diff_on));
    a_cursor: assert property (@(posedge clk) check_now |-> cursor_on == m_cursor)
        else report_mismatch("cursor_on", m_cursor, $sampled(cursor_on));
    a_pan_x1: assert property (@(posedge clk) check_now |-> int'(pan_x1) == m_pan_x1)
        else report_mismatch("pan_x1", m_pan_x1, int'($sampled(pan_x1)));
    a_pan_x2: assert property (@(posedge clk) check_now |-> int'(pan_x2) == m_pan_x2)
        else report_mismatch("pan_x2", m_pan_x2, int'($sampled(pan_x2)));
    a_pan_y: assert property (@(posedge clk) check_now |-> int'(pan_y) == m_pan_y)
        else report_mismatch("pan_y", m_pan_y, int'($sampled(pan_y)));
    a_freq: assert property (@(posedge clk) check_now |-> int'(target_freq) == m_freq)
        else report_mismatch("target_freq", m_freq, int'($sampled(target_freq)));
    a_vpp: assert property (@(posedge clk) check_now |-> int'(target_vpp) == m_vpp)
        else report_mismatch("target_vpp", m_vpp, int'($sampled(target_vpp)));
    a_active: assert property (@(posedge clk) disable iff (!reset) key_active == active_exp)
        else report_mismatch("key_active", active_exp, $sampled(key_active));

    function automatic logic on_screen(touch_pkg::key_t k, touch_pkg::screen_t s);
        case (s)
            touch_pkg::screen_menu:     return k inside {touch_pkg::menu_scope,
                                                         touch_pkg::menu_keypad};
            touch_pkg::screen_scope:    return k inside {[touch_pkg::scope_back :
                                                          touch_pkg::scope_pan_y_down]};
            touch_pkg::screen_spectrum: return k == touch_pkg::spectrum_back;
            default:                    return k inside {[touch_pkg::fre_0 :
                                                          touch_pkg::keypad_back]};
        endcase
    endfunction

    function automatic int place(int entered);
        return (entered == 0) ? 100 : (entered == 1) ? 10 : 1;
    endfunction

    task automatic clear_scope_model();
        m_trace1   = 1'b0;
        m_trace2   = 1'b0;
        m_spectrum = 1'b0;
        m_run      = 1'b0;
        m_diff     = 1'b0;
        m_cursor   = 1'b0;
        m_pan_x1   = 0;
        m_pan_x2   = 1;
        m_pan_y    = 0;
    endtask

    task automatic clear_targets_model();
        m_freq     = 0;
        m_vpp      = 0;
        m_freq_cnt = 0;
        m_vpp_cnt  = 0;
    endtask

    task automatic apply_key(input touch_pkg::key_t k, input int digit);
        case (k)
            touch_pkg::menu_scope:       m_screen = touch_pkg::screen_scope;
            touch_pkg::menu_keypad:      m_screen = touch_pkg::screen_keypad;
            touch_pkg::scope_back:       m_screen = touch_pkg::screen_menu;
            touch_pkg::keypad_back:      m_screen = touch_pkg::screen_menu;
            touch_pkg::spectrum_back:    m_screen = touch_pkg::screen_scope;
            touch_pkg::scope_spectrum: begin
                m_screen   = touch_pkg::screen_spectrum;
                m_spectrum = ~m_spectrum;
            end
            touch_pkg::scope_trace1:     m_trace1 = ~m_trace1;
            touch_pkg::scope_trace2:     m_trace2 = ~m_trace2;
            touch_pkg::scope_stop:       m_run    = ~m_run;
            touch_pkg::scope_diff:       m_diff   = ~m_diff;
            touch_pkg::scope_cursor:     m_cursor = ~m_cursor;
            touch_pkg::scope_pan_x1:     m_pan_x1 = (m_pan_x1 + 1) % 8;
            touch_pkg::scope_pan_x2:     m_pan_x2 = (m_pan_x2 + 1) % 8;
            touch_pkg::scope_pan_y_up:   m_pan_y  = (m_pan_y + 1) % 32;
            touch_pkg::scope_pan_y_down: m_pan_y  = (m_pan_y + 31) % 32;
            touch_pkg::scope_clear:      clear_scope_model();
            touch_pkg::keypad_clear:     clear_targets_model();
            default: begin
                if (k inside {[touch_pkg::fre_0 : touch_pkg::fre_9]} && m_freq_cnt < 3) begin
                    m_freq = m_freq + digit * place(m_freq_cnt);
                    m_freq_cnt++;
                end else if (k inside {[touch_pkg::vpp_0 : touch_pkg::vpp_9]} &&
                             m_vpp_cnt < 3) begin
                    m_vpp = m_vpp + digit * place(m_vpp_cnt);
                    m_vpp_cnt++;
                end
            end
        endcase
    endtask

    task automatic check_outputs();
        @(negedge clk);
        check_now = 1'b1;
        checks++;
        @(negedge clk);
        check_now = 1'b0;
    endtask

    // touch the centre of a rectangle for hold cycles, then lift
    task automatic press(input touch_pkg::key_t k, input int xl, input int xh,
                         input int yl, input int yh, input int hold, input int digit);
        logic hits;
        hits = on_screen(k, m_screen);
        @(negedge clk);
        touch_x = touch_pkg::coord_t'((xl + xh) / 2);
        touch_y = touch_pkg::coord_t'((yl + yh) / 2);
        @(negedge clk);
        active_exp = hits;   // key registered one cycle after the coordinate
        repeat (hold - 1) @(negedge clk);
        touch_x = OFF_X;
        touch_y = OFF_Y;
        @(negedge clk);
        active_exp = 1'b0;
        if (hits)
            apply_key(k, digit);
        repeat (6) @(negedge clk);
        check_outputs();
    endtask

    task automatic tap(input touch_pkg::key_t k, input int xl, input int xh,
                       input int yl, input int yh);
        press(k, xl, xh, yl, yh, 1 + int'($urandom % 6), 0);
    endtask

    task automatic tap_digit(input logic fre, input int d);
        if (fre)
            press(touch_pkg::key_t'(touch_pkg::fre_0 + d), `RECT_FRE(d),
                  1 + int'($urandom % 6), d);
        else
            press(touch_pkg::key_t'(touch_pkg::vpp_0 + d), `RECT_VPP(d),
                  1 + int'($urandom % 6), d);
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s done, %0d errors", tests, name, errors - test_base);
        test_base = errors;
    endtask

    initial begin
        #(WATCHDOG * CLK_PERIOD);
        $display("timeout, the tests did not finish in %0d cycles", WATCHDOG);
        $display("Regression failed");
        $finish;
    end

    initial begin
        void'($urandom(32'hf10d6bb9));
        clk        = 1'b0;
        reset      = 1'b0;
        touch_x    = OFF_X;
        touch_y    = OFF_Y;
        check_now  = 1'b0;
        active_exp = 1'b0;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        test_base  = 0;
        m_screen   = touch_pkg::screen_menu;
        clear_scope_model();
        clear_targets_model();
        repeat (16) @(negedge clk);
        reset = 1'b1;

        check_outputs();
        end_test("reset values");

        tap(touch_pkg::scope_trace1, `RECT_SCOPE_TRACE1);   // not on menu
        tap(touch_pkg::menu_scope, `RECT_MENU_SCOPE);
        tap(touch_pkg::scope_spectrum, `RECT_SCOPE_SPECTRUM);
        tap(touch_pkg::scope_trace1, `RECT_SCOPE_TRACE1);   // not on spectrum
        tap(touch_pkg::spectrum_back, `RECT_SPECTRUM_BACK);
        tap(touch_pkg::scope_back, `RECT_SCOPE_BACK);
        tap(touch_pkg::menu_keypad, `RECT_MENU_KEYPAD);
        tap(touch_pkg::menu_scope, `RECT_MENU_SCOPE);        // not on keypad
        tap(touch_pkg::keypad_back, `RECT_KEYPAD_BACK);
        end_test("navigation");

        tap(touch_pkg::menu_scope, `RECT_MENU_SCOPE);
        repeat (2) begin
            tap(touch_pkg::scope_trace1, `RECT_SCOPE_TRACE1);
            tap(touch_pkg::scope_trace2, `RECT_SCOPE_TRACE2);
            tap(touch_pkg::scope_stop, `RECT_SCOPE_STOP);
            tap(touch_pkg::scope_diff, `RECT_SCOPE_DIFF);
            tap(touch_pkg::scope_cursor, `RECT_SCOPE_CURSOR);
        end
        tap(touch_pkg::scope_spectrum, `RECT_SCOPE_SPECTRUM);
        tap(touch_pkg::spectrum_back, `RECT_SPECTRUM_BACK);
        end_test("scope toggles");

        repeat (9) tap(touch_pkg::scope_pan_x1, `RECT_SCOPE_PAN_X1);
        repeat (9) tap(touch_pkg::scope_pan_x2, `RECT_SCOPE_PAN_X2);
        repeat (3) tap(touch_pkg::scope_pan_y_down, `RECT_SCOPE_PAN_Y_DOWN);
        repeat (2) tap(touch_pkg::scope_pan_y_up, `RECT_SCOPE_PAN_Y_UP);
        tap(touch_pkg::scope_stop, `RECT_SCOPE_STOP);   // a flag for clear to drop
        tap(touch_pkg::scope_clear, `RECT_SCOPE_CLEAR);
        tap(touch_pkg::scope_back, `RECT_SCOPE_BACK);
        end_test("pan counters");

        tap(touch_pkg::menu_keypad, `RECT_MENU_KEYPAD);
        repeat (5) tap_digit(1'b1, int'($urandom % 10));
        repeat (5) tap_digit(1'b0, int'($urandom % 10));
        tap(touch_pkg::keypad_clear, `RECT_KEYPAD_CLEAR);
        repeat (4) tap_digit(1'($urandom % 2), int'($urandom % 10));
        tap(touch_pkg::keypad_clear, `RECT_KEYPAD_CLEAR);
        tap(touch_pkg::keypad_back, `RECT_KEYPAD_BACK);
        end_test("digit entry");

        tap(touch_pkg::menu_scope, `RECT_MENU_SCOPE);
        for (int h = 1; h <= 6; h++)
            press(touch_pkg::scope_trace1, `RECT_SCOPE_TRACE1, h, 0);
        tap(touch_pkg::scope_back, `RECT_SCOPE_BACK);
        end_test("hold lengths");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule
